// File: hw/cpu_defines.svh
// Width, register-count, field-size and reset-address macros for the core.
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width.
`define XLEN 32

// Register file geometry.
`define REG_COUNT 32
`define REG_IDX_W 5

// Instruction field sizes.
`define OPCODE_W 6
`define IMM_W    16

`define RESET_PC 32'h0000_0000 // First fetch address.

`endif

// File: hw/isa_pkg.sv
// Opcode and operation-class enums, instruction layout and decoded-operation struct.
`default_nettype none
`include "cpu_defines.svh"

package isa_pkg;

  // Encodings follow the instruction set order, add = 0 up to halt = 17.
  typedef enum logic [`OPCODE_W-1:0] {
    op_add, op_addi, op_sub, op_subi, op_mul, op_muli,
    op_or, op_ori, op_and, op_andi, op_xor, op_xori,
    op_ldr, op_str, op_bz, op_beq, op_jump, op_halt
  } opcode_e;

  typedef enum logic [3:0] {
    cls_alu_reg, cls_alu_imm, cls_load, cls_store,
    cls_branch_zero, cls_branch_equal, cls_jump, cls_halt, cls_nop
  } op_class_e;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rd_idx; // Register-form destination.
    logic [10:0]           func;   // Unused by this instruction set.
  } rtype_low_t;

  // Low half is either rd plus spare bits or the 16-bit immediate.
  typedef union packed {
    rtype_low_t         rtype;
    logic [`IMM_W-1:0]  imm;
  } instr_low_t;

  typedef struct packed {
    logic [`OPCODE_W-1:0]  opcode;
    logic [`REG_IDX_W-1:0] rs_idx;
    logic [`REG_IDX_W-1:0] rt_idx;
    instr_low_t            low;
  } instr_t;

  typedef struct packed {
    opcode_e               op;
    op_class_e             op_class;
    logic [`REG_IDX_W-1:0] src_a;
    logic [`REG_IDX_W-1:0] src_b;
    logic [`REG_IDX_W-1:0] dest;
    logic                  we;
    logic [`XLEN-1:0]      imm;    // Already sign-extended.
  } decoded_t;

endpackage

`default_nettype wire

// File: hw/bus_pkg.sv
// Request and response payloads of the four-phase memory bus.
`default_nettype none
`include "cpu_defines.svh"

package bus_pkg;

  // Outbound payload, held stable while req is high.
  typedef struct packed {
    logic [`XLEN-1:0] addr;  // Byte address.
    logic [`XLEN-1:0] wdata;
    logic             we;    // High for a store.
  } mem_req_t;

  // Inbound payload, valid while ack is high.
  typedef struct packed {
    logic [`XLEN-1:0] rdata;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/instr_decoder.sv
// Combinational instruction decoder: register indices, immediate and operation class.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module instr_decoder import isa_pkg::*; (
  input  instr_t   instr,
  output decoded_t dec
);

  opcode_e   op;
  op_class_e op_class;

  assign op = opcode_e'(instr.opcode); // Out-of-range codes land in the default arm.

  always_comb begin
    case (op)
      op_add, op_sub, op_mul, op_or, op_and, op_xor: begin
        op_class = cls_alu_reg;
      end
      op_addi, op_subi, op_muli, op_ori, op_andi, op_xori: begin
        op_class = cls_alu_imm;
      end
      op_ldr:  op_class = cls_load;
      op_str:  op_class = cls_store;
      op_bz:   op_class = cls_branch_zero;
      op_beq:  op_class = cls_branch_equal;
      op_jump: op_class = cls_jump;
      op_halt: op_class = cls_halt;
      default: op_class = cls_nop;
    endcase
  end

  always_comb begin
    dec.op       = op;
    dec.op_class = op_class;
    dec.src_a    = instr.rs_idx;
    dec.src_b    = instr.rt_idx;
    // Register forms write rd; immediate forms and loads write rt.
    if (op_class == cls_alu_reg) begin
      dec.dest = instr.low.rtype.rd_idx;
    end else begin
      dec.dest = instr.rt_idx;
    end
    dec.we  = op_class inside {cls_alu_reg, cls_alu_imm, cls_load};
    dec.imm = {{(`XLEN-`IMM_W){instr.low.imm[`IMM_W-1]}}, instr.low.imm};
  end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
// General-purpose register file, two asynchronous read ports and one synchronous write port.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`REG_IDX_W-1:0] rd_idx_a,
  input  logic [`REG_IDX_W-1:0] rd_idx_b,
  output logic [`XLEN-1:0]      rd_data_a,
  output logic [`XLEN-1:0]      rd_data_b,
  input  logic                  we,
  input  logic [`REG_IDX_W-1:0] wr_idx,
  input  logic [`XLEN-1:0]      wr_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0; // All registers start at zero.
      end
    end else if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  // Write index comes from the core sequencer.
  a_wr_idx_known: assert property (@(posedge clk) disable iff (rst) we |-> !$isunknown(wr_idx))
    else $error("reg_file write with unknown index");

endmodule

`default_nettype wire

// File: hw/alu.sv
// ALU: arithmetic and logic results, load/store address and branch condition.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module alu import isa_pkg::*; (
  input  decoded_t         dec,
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  output logic [`XLEN-1:0] result,
  output logic             branch_taken
);

  logic [`XLEN-1:0] operand_b;

  // Only register forms use rt as the second operand.
  assign operand_b = (dec.op_class == cls_alu_reg) ? b : dec.imm;

  always_comb begin
    case (dec.op)
      op_add, op_addi, op_ldr, op_str: result = a + operand_b; // Includes address sum.
      op_sub, op_subi:                 result = a - operand_b;
      op_mul, op_muli:                 result = a * operand_b; // Low 32 bits kept.
      op_or, op_ori:                   result = a | operand_b;
      op_and, op_andi:                 result = a & operand_b;
      op_xor, op_xori:                 result = a ^ operand_b;
      default:                         result = '0;
    endcase
  end

  always_comb begin
    case (dec.op_class)
      cls_branch_zero:  branch_taken = (a == '0);
      cls_branch_equal: branch_taken = (a == b);
      cls_jump:         branch_taken = 1'b1;
      default:          branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hw/bus_master.sv
// Four-phase req/ack bus master, one transaction per start pulse.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module bus_master import bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  input  mem_req_t cmd,
  output logic     finish,
  output mem_rsp_t rsp,
  output logic     req,
  input  logic     ack,
  output mem_req_t bus_req,
  input  mem_rsp_t bus_rsp
);

  typedef enum logic [1:0] {bm_idle, bm_req, bm_release} bm_state_e;

  bm_state_e state;
  mem_req_t  cmd_q;
  mem_rsp_t  rsp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= bm_idle;
      finish <= 1'b0;
    end else begin
      finish <= 1'b0;
      case (state)
        bm_idle:    if (start) state <= bm_req;
        bm_req:     if (ack) state <= bm_release; // Drop req next.
        bm_release: begin
          if (!ack) begin // Handshake closed.
            state  <= bm_idle;
            finish <= 1'b1;
          end
        end
        default:    state <= bm_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == bm_idle && start) cmd_q <= cmd;
    if (state == bm_req && ack) rsp_q <= bus_rsp; // Data valid with ack.
  end

  assign req     = (state == bm_req);
  assign bus_req = cmd_q;
  assign rsp     = rsp_q;

  a_payload_stable: assert property (@(posedge clk) disable iff (rst)
    req |=> !req || $stable(bus_req))
    else $error("bus payload changed while req high");

  a_req_holds: assert property (@(posedge clk) disable iff (rst) req && !ack |=> req)
    else $error("req dropped before ack");

  // The core may only start once the previous finish has been seen.
  a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> state == bm_idle)
    else $error("start while transaction in progress");

endmodule

`default_nettype wire

// File: hw/cpu_core.sv
// Multi-cycle core top: PC, instruction register, stage sequencer and bus hookup.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module cpu_core import isa_pkg::*, bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  output logic     req,
  input  logic     ack,
  output mem_req_t bus_req,
  input  mem_rsp_t bus_rsp,
  output logic     done
);

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_mem, st_writeback, st_halted
  } stage_e;

  stage_e           stage;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] next_pc;
  logic [`XLEN-1:0] target_pc;
  instr_t           ir;
  decoded_t         dec;
  decoded_t         dec_q;
  logic [`XLEN-1:0] rd_data_a;
  logic [`XLEN-1:0] rd_data_b;
  logic [`XLEN-1:0] a_q;
  logic [`XLEN-1:0] b_q;
  logic [`XLEN-1:0] alu_result;
  logic [`XLEN-1:0] result_q;
  logic [`XLEN-1:0] load_data;
  logic             branch_taken;
  logic             bus_busy;
  logic             start;
  logic             finish;
  mem_req_t         cmd;
  mem_rsp_t         rsp;
  logic             rf_we;
  logic [`XLEN-1:0] rf_wdata;

  instr_decoder i_decoder (.instr(ir), .dec(dec));

  reg_file i_reg_file (
    .clk(clk), .rst(rst),
    .rd_idx_a(dec.src_a), .rd_idx_b(dec.src_b),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
    .we(rf_we), .wr_idx(dec_q.dest), .wr_data(rf_wdata)
  );

  alu i_alu (.dec(dec_q), .a(a_q), .b(b_q), .result(alu_result), .branch_taken(branch_taken));

  bus_master i_bus_master (
    .clk(clk), .rst(rst), .start(start), .cmd(cmd), .finish(finish), .rsp(rsp),
    .req(req), .ack(ack), .bus_req(bus_req), .bus_rsp(bus_rsp)
  );

  // One transaction per fetch or memory stage.
  assign start     = (stage == st_fetch || stage == st_mem) && !bus_busy;
  assign cmd.addr  = (stage == st_mem) ? result_q : pc;
  assign cmd.wdata = b_q; // rt value for str.
  assign cmd.we    = (stage == st_mem) && (dec_q.op_class == cls_store);

  // Branch offsets count words from the branch's own address.
  always_comb begin
    if (!branch_taken) begin
      target_pc = pc + `XLEN'd4;
    end else if (dec_q.op_class == cls_jump) begin
      target_pc = a_q;
    end else begin
      target_pc = pc + {dec_q.imm[`XLEN-3:0], 2'b00};
    end
  end

  assign rf_we    = (stage == st_writeback) && dec_q.we;
  assign rf_wdata = (dec_q.op_class == cls_load) ? load_data : result_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage    <= st_fetch;
      pc       <= `RESET_PC;
      done     <= 1'b0;
      bus_busy <= 1'b0;
    end else begin
      if (start) begin
        bus_busy <= 1'b1;
      end else if (finish) begin
        bus_busy <= 1'b0;
      end
      case (stage)
        st_fetch:   if (finish) stage <= st_decode;
        st_decode:  stage <= st_execute;
        st_execute: begin
          if (dec_q.op_class inside {cls_load, cls_store}) begin
            stage <= st_mem;
          end else begin
            stage <= st_writeback;
          end
        end
        st_mem:     if (finish) stage <= st_writeback;
        st_writeback: begin
          pc <= next_pc;
          if (dec_q.op_class == cls_halt) begin
            done  <= 1'b1;
            stage <= st_halted;
          end else begin
            stage <= st_fetch;
          end
        end
        default:    stage <= st_halted; // Parked for good.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (stage == st_fetch && finish) ir <= rsp.rdata;
    if (stage == st_decode) begin
      dec_q <= dec;
      a_q   <= rd_data_a;
      b_q   <= rd_data_b;
    end
    if (stage == st_execute) begin
      result_q <= alu_result;
      next_pc  <= target_pc;
    end
    if (stage == st_mem && finish) load_data <= rsp.rdata;
  end

  a_stage_order: assert property (@(posedge clk) disable iff (rst)
    (stage != $past(stage)) |-> (stage > $past(stage)) || (stage == st_fetch))
    else $error("stage moved backwards");

  a_done_holds: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else $error("done fell after halt");

endmodule

`default_nettype wire

// File: sim/mem_responder.sv
// Bus memory model: big-endian byte array with LFSR-random ack delays.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module mem_responder import bus_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     req,
  output logic     ack,
  input  mem_req_t bus_req,
  output mem_rsp_t bus_rsp,
  output logic     stuck
);

  localparam int MEM_BYTES  = 1024;
  localparam int HOLD_LIMIT = 100; // Cycles req may stay high after ack.

  logic [7:0]  mem [MEM_BYTES];
  logic [31:0] lfsr;

  // Fibonacci LFSR, taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Waits 0 to 3 cycles, one LFSR step per delay bit.
  task automatic random_wait();
    logic [1:0] delay;
    lfsr     = lfsr_step(lfsr);
    delay[1] = lfsr[0];
    lfsr     = lfsr_step(lfsr);
    delay[0] = lfsr[0];
    repeat (delay) @(negedge clk);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    logic [9:0] idx;
    idx = addr[9:0];
    mem[idx]         = data[31:24]; // Most significant byte first.
    mem[idx + 10'd1] = data[23:16];
    mem[idx + 10'd2] = data[15:8];
    mem[idx + 10'd3] = data[7:0];
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [9:0] idx;
    idx = addr[9:0];
    return {mem[idx], mem[idx + 10'd1], mem[idx + 10'd2], mem[idx + 10'd3]};
  endfunction

  initial begin
    int held;
    ack     = 1'b0;
    bus_rsp = '0;
    stuck   = 1'b0;
    lfsr    = 32'h42da;
    forever begin
      @(negedge clk);
      if (!rst && req) begin
        random_wait();
        if (bus_req.we) begin
          write_word(bus_req.addr, bus_req.wdata);
        end else begin
          bus_rsp.rdata = read_word(bus_req.addr);
        end
        ack  = 1'b1; // Read data valid from here.
        held = 0;
        while (req && held < HOLD_LIMIT) begin
          @(negedge clk);
          held++;
        end
        if (req) begin
          stuck = 1'b1;
          $display("Bus master kept req high for %0d cycles after ack", HOLD_LIMIT);
        end
        random_wait();
        ack = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_cpu.sv
// Testbench top with trace loading, clock and reset, and store traffic and done checks for cpu_core.
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu import bus_pkg::*; ();

  localparam int TRACE_WORDS     = 256;
  localparam int FIRST_REQ_LIMIT = 50;
  localparam int DONE_LIMIT      = 5000;
  localparam int IDLE_CYCLES     = 50;

  logic        clk;
  logic        rst;
  logic        req;
  logic        ack;
  mem_req_t    bus_req;
  mem_rsp_t    bus_rsp;
  logic        done;
  logic        stuck;
  logic [31:0] trace [TRACE_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          store_count;
  int          errors;
  logic        req_last;

  cpu_core i_dut (
    .clk(clk), .rst(rst), .req(req), .ack(ack),
    .bus_req(bus_req), .bus_rsp(bus_rsp), .done(done)
  );

  mem_responder i_mem (
    .clk(clk), .rst(rst), .req(req), .ack(ack),
    .bus_req(bus_req), .bus_rsp(bus_rsp), .stuck(stuck)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
  endtask

  // Program records go into the memory model, store records into the queues.
  task automatic load_trace();
    int p;
    p = 0;
    $readmemh("sim/cpu_trace.txt", trace);
    while (p < TRACE_WORDS - 6 && (trace[p] == 32'd0 || trace[p] == 32'd1)) begin
      if (trace[p] == 32'd0) begin
        for (int i = 0; i < 4; i++) begin
          i_mem.write_word(trace[p + 1] + 32'(4 * i), trace[p + 2 + i]);
        end
        p += 6;
      end else begin
        exp_addr.push_back(trace[p + 1]);
        exp_data.push_back(trace[p + 2]);
        p += 3;
      end
    end
    if (trace[p] !== 32'd2) begin
      errors++;
      $display("Trace file has a bad record or no end record at word %0d", p);
    end
  endtask

  // Every new store request is compared with the next trace entry.
  always @(negedge clk) begin
    if (rst) begin
      req_last = 1'b0;
    end else begin
      if (req && !req_last && bus_req.we) begin
        if (store_count >= exp_addr.size()) begin
          errors++;
          $display("Store to %h at t=%0t has no trace entry left", bus_req.addr, $time);
        end else begin
          if (bus_req.addr !== exp_addr[store_count]) begin
            report_mismatch("bus_req.addr", exp_addr[store_count], bus_req.addr);
          end
          if (bus_req.wdata !== exp_data[store_count]) begin
            report_mismatch("bus_req.wdata", exp_data[store_count], bus_req.wdata);
          end
        end
        store_count++;
      end
      req_last = req;
    end
  end

  initial begin
    bit ok;
    int wait_cycles;
    rst         = 1'b1;
    store_count = 0;
    errors      = 0;
    ok          = 1'b1;
    load_trace();
    repeat (2) @(negedge clk);
    rst = 1'b0;

    wait_cycles = 0;
    while (!req && wait_cycles < FIRST_REQ_LIMIT) begin
      if (done !== 1'b0) begin
        report_mismatch("done", 32'd0, {31'b0, done});
      end
      @(negedge clk);
      wait_cycles++;
    end
    if (!req) begin
      errors++;
      ok = 1'b0;
      $display("No bus request within %0d cycles of reset", FIRST_REQ_LIMIT);
    end else begin
      // First request is the fetch at the reset PC.
      if (bus_req.addr !== `RESET_PC) begin
        report_mismatch("bus_req.addr", `RESET_PC, bus_req.addr);
      end
      if (bus_req.we !== 1'b0) begin
        report_mismatch("bus_req.we", 32'd0, {31'b0, bus_req.we});
      end
      if (done !== 1'b0) begin
        report_mismatch("done", 32'd0, {31'b0, done});
      end
    end

    if (ok) begin
      wait_cycles = 0;
      while (!done && wait_cycles < DONE_LIMIT) begin
        @(negedge clk);
        wait_cycles++;
      end
      if (!done) begin
        errors++;
        ok = 1'b0;
        $display("done did not rise within %0d cycles", DONE_LIMIT);
      end
    end

    if (ok) begin
      for (int i = 0; i < IDLE_CYCLES; i++) begin // Core must stay parked.
        @(negedge clk);
        if (done !== 1'b1) begin
          report_mismatch("done", 32'd1, {31'b0, done});
        end
        if (req !== 1'b0) begin
          report_mismatch("req", 32'd0, {31'b0, req});
        end
      end
      if (store_count != exp_addr.size()) begin
        report_mismatch("store count", 32'(exp_addr.size()), 32'(store_count));
      end
    end

    if (stuck) begin
      errors++;
      $display("Memory model saw req held high long after ack");
    end
    $display("Stores %0d of %0d expected, errors %0d", store_count, exp_addr.size(), errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/cpu_trace.txt
// Kind 0: byte address, then four program words stored big-endian from there.
// Kind 1: expected store address and value in order; kind 2 ends the trace.
0 00000000 04010007 0402fffd 00221800 34030200
0 00000010 08221800 34030204 10221800 34030208
0 00000020 18221800 3403020c 20221800 34030210
0 00000030 28221800 34030214 0c24fff0 34040218
0 00000040 1424fffe 3404021c 1c248000 34040220
0 00000050 244400f0 34040224 2c24ffff 34040228
0 00000060 04060300 30c5ff08 04a50001 3405022c
0 00000070 38600002 34010230 38000002 34010234
0 00000080 3c220002 34020238 3c630002 3402023c
0 00000090 040800a0 41000000 34010240 44000000
0 000000a0 34080244 44000000 44000000 44000000
// Register forms: add, sub, mul, or, and, xor of 7 and -3.
1 00000200 00000004
1 00000204 0000000a
1 00000208 ffffffeb
1 0000020c ffffffff
1 00000210 00000005
1 00000214 fffffffa
// Immediate forms with sign-extended immediates.
1 00000218 00000017
1 0000021c fffffff2
1 00000220 ffff8007
1 00000224 000000f0
1 00000228 fffffff8
// Load of 0x208 through a negative offset, plus one.
1 0000022c ffffffec
// Branch path markers: bz not taken, beq not taken, jump target.
1 00000230 00000007
1 00000238 fffffffd
1 00000244 000000a0
2

// File: sim.f
+incdir+hw
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/bus_master.sv
hw/cpu_core.sv
sim/mem_responder.sv
sim/tb_cpu.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_cpu
FILELIST  := sim.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_cpu with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Checks failed" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
